//--- hdl/kl_sbus_pkg.sv
`default_nettype none

package kl_sbus_pkg;

  // Storage bus word address and data widths
  localparam int ADR_W = 22;
  localparam int WORD_W = 36;

  // Physical word address as seen on SBUS
  typedef logic [ADR_W-1:0] adr_t;
  // One 36-bit memory word, parity travels separately
  typedef logic [WORD_W-1:0] word_t;

  // Words backed by the array, anything above is non-existent
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW = $clog2(MEM_WORDS);
  // Index of an even/odd word pair inside the array
  typedef logic [MEM_AW-2:0] pair_idx_t;

  // Cycles from sampled rq to acknowledge
  localparam int ACK_DELAY = 2;
  // Cycles from acknowledge to first read data valid
  localparam int RD_DELAY = 2;

  // Delay counter shared by acknowledge and read timing
  localparam int DLY_MAX = (ACK_DELAY > RD_DELAY) ? ACK_DELAY : RD_DELAY;
  localparam int DLY_W = $clog2(DLY_MAX + 1);
  typedef logic [DLY_W-1:0] dly_t;

endpackage

`default_nettype wire

//--- hdl/kl_mbox_pkg.sv
`default_nettype none

package kl_mbox_pkg;

  // Word select of a pair
  // Bit 0 is word A (even), bit 1 is word B (odd)
  typedef logic [1:0] wmask_t;

  // Memory port sequencer states
  typedef enum logic [2:0] {
    idle,
    request,
    wait_ack,
    xfer,
    finish
  } port_state_e;

  // Cycles without acknowledge before the port gives up
  localparam int NXM_TIMEOUT = 8;
  // Counter wide enough to reach the timeout
  typedef logic [$clog2(NXM_TIMEOUT)-1:0] nxm_cnt_t;

endpackage

`default_nettype wire

//--- hdl/mbox_mem_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mbox_mem_if;
  import kl_sbus_pkg::*;

  // Request strobes from the memory port
  logic  mem_rq;
  logic  mem_rd_rq;
  logic  mem_wr_rq;
  logic  mem_start_a;
  logic  mem_start_b;
  // Address and its hold enable
  logic  sbus_adr_hold;
  adr_t  pma;
  // Write data path, mem_data_to_mem turns the bus around
  logic  mem_data_to_mem;
  word_t mb;
  logic  data_valid_a_out;
  logic  data_valid_b_out;
  // Diagnostic controls
  logic  diag_adr_par;
  logic  diag_data_par;
  logic  diag_mem_reset;

  // Responses passed back by the translator
  logic  mem_ackn_a;
  logic  mem_ackn_b;
  logic  mem_data_valid_a;
  logic  mem_data_valid_b;
  word_t mem_data_in;
  logic  mem_error;
  logic  adr_par_err;
  logic  mem_data_par_err;

  modport port (
    output mem_rq, mem_rd_rq, mem_wr_rq, mem_start_a, mem_start_b,
    output sbus_adr_hold, pma, mem_data_to_mem, mb,
    output data_valid_a_out, data_valid_b_out,
    output diag_adr_par, diag_data_par, diag_mem_reset,
    input  mem_ackn_a, mem_ackn_b, mem_data_valid_a, mem_data_valid_b,
    input  mem_data_in, mem_error, adr_par_err, mem_data_par_err
  );

  modport xlat (
    input  mem_rq, mem_rd_rq, mem_wr_rq, mem_start_a, mem_start_b,
    input  sbus_adr_hold, pma, mem_data_to_mem, mb,
    input  data_valid_a_out, data_valid_b_out,
    input  diag_adr_par, diag_data_par, diag_mem_reset,
    output mem_ackn_a, mem_ackn_b, mem_data_valid_a, mem_data_valid_b,
    output mem_data_in, mem_error, adr_par_err, mem_data_par_err
  );

endinterface

`default_nettype wire

//--- hdl/sbus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface sbus_if;
  import kl_sbus_pkg::*;

  // Request side, driven by the translator
  logic  rq;
  logic  rd_rq;
  logic  wr_rq;
  logic  start_a;
  logic  start_b;
  adr_t  adr;
  logic  adr_par;
  // Data toward memory, split from the return path
  word_t d_out;
  logic  data_par_out;
  logic  data_valid_a_out;
  logic  data_valid_b_out;
  logic  mem_reset;

  // Response side, driven by the memory controller
  logic  ackn_a;
  logic  ackn_b;
  logic  data_valid_a;
  logic  data_valid_b;
  word_t d_in;
  logic  data_par_in;
  logic  error;
  logic  adr_par_err;

  modport mbox (
    output rq, rd_rq, wr_rq, start_a, start_b, adr, adr_par,
    output d_out, data_par_out, data_valid_a_out, data_valid_b_out, mem_reset,
    input  ackn_a, ackn_b, data_valid_a, data_valid_b,
    input  d_in, data_par_in, error, adr_par_err
  );

  modport mem (
    input  rq, rd_rq, wr_rq, start_a, start_b, adr, adr_par,
    input  d_out, data_par_out, data_valid_a_out, data_valid_b_out, mem_reset,
    output ackn_a, ackn_b, data_valid_a, data_valid_b,
    output d_in, data_par_in, error, adr_par_err
  );

endinterface

`default_nettype wire

//--- hdl/mt0.sv
`timescale 1ns/10ps
`default_nettype none

module mt0 (
  input wire       sbus_clk,
  input wire       arst_n,
  mbox_mem_if.xlat mbox,
  sbus_if.mbox     sbus
);
  import kl_sbus_pkg::*;

  // Held SBUS address
  adr_t adr_q;
  logic to_mem;

  // Address follows pma while hold is up, keeps its value otherwise
  always_ff @(posedge sbus_clk or negedge arst_n) begin
    if (!arst_n) begin
      adr_q <= '0;
    end else if (mbox.sbus_adr_hold) begin
      adr_q <= mbox.pma;
    end
  end

  assign to_mem = mbox.mem_data_to_mem;

  // Strobes and address toward memory
  always_comb begin
    sbus.rq        = mbox.mem_rq;
    sbus.rd_rq     = mbox.mem_rd_rq;
    sbus.wr_rq     = mbox.mem_wr_rq;
    sbus.start_a   = mbox.mem_start_a;
    sbus.start_b   = mbox.mem_start_b;
    sbus.mem_reset = mbox.diag_mem_reset;
    sbus.adr       = adr_q;
    // Odd parity over the held address, diag flips it
    sbus.adr_par   = ~^adr_q ^ mbox.diag_adr_par;
  end

  // Acknowledge and error strobes back to the MBOX
  always_comb begin
    mbox.mem_ackn_a  = sbus.ackn_a;
    mbox.mem_ackn_b  = sbus.ackn_b;
    mbox.mem_error   = sbus.error;
    mbox.adr_par_err = sbus.adr_par_err;
  end

  // Data turnaround
  always_comb begin
    // Write direction, only while the port owns the data lines
    sbus.d_out            = to_mem ? mbox.mb : '0;
    sbus.data_valid_a_out = to_mem & mbox.data_valid_a_out;
    sbus.data_valid_b_out = to_mem & mbox.data_valid_b_out;
    // Odd write parity, forced bad under diag
    sbus.data_par_out     = to_mem & (~^mbox.mb ^ mbox.diag_data_par);
    // Read direction
    mbox.mem_data_in      = to_mem ? '0 : sbus.d_in;
    mbox.mem_data_valid_a = ~to_mem & sbus.data_valid_a;
    mbox.mem_data_valid_b = ~to_mem & sbus.data_valid_b;
    // Word plus parity must hold an odd number of ones
    mbox.mem_data_par_err = ~to_mem & (sbus.data_valid_a | sbus.data_valid_b) &
                            ~(^{sbus.data_par_in, sbus.d_in});
  end

endmodule

`default_nettype wire

//--- hdl/mbox_mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module mbox_mem_port (
  input  wire                     sbus_clk,
  input  wire                     arst_n,
  input  wire                     crobar,
  input  wire                     req,
  input  wire                     req_wr,
  input  wire kl_mbox_pkg::wmask_t req_mask,
  input  wire kl_sbus_pkg::adr_t  req_adr,
  input  wire kl_sbus_pkg::word_t req_wdata_a,
  input  wire kl_sbus_pkg::word_t req_wdata_b,
  input  wire                     diag_adr_par,
  input  wire                     diag_data_par,
  output logic                    busy,
  output logic                    done,
  output kl_sbus_pkg::word_t      rdata_a,
  output kl_sbus_pkg::word_t      rdata_b,
  output logic                    err_nxm,
  output logic                    err_adr_par,
  output logic                    err_data_par,
  mbox_mem_if.port                mem
);
  import kl_sbus_pkg::*;
  import kl_mbox_pkg::*;

  port_state_e state, state_d;
  // Latched request
  logic        rq_wr;
  wmask_t      rq_mask;
  logic        rq_diag_adr;
  logic        rq_diag_data;
  adr_t        rq_adr;
  word_t       rq_wdata_a;
  word_t       rq_wdata_b;
  // Transfer progress
  logic        word_b;
  wmask_t      pend, pend_d;
  nxm_cnt_t    timer;
  word_t       rd_a, rd_a_d;
  word_t       rd_b, rd_b_d;
  logic        dpar, dpar_d;
  logic        ack, timeout, nxm_hit, apar_hit, rq_on;

  assign ack     = mem.mem_ackn_a | mem.mem_ackn_b;
  assign timeout = (timer == nxm_cnt_t'(NXM_TIMEOUT - 1));
  assign busy    = (state != idle);
  assign done    = (state == finish);
  // Request strobes stay up until memory answers or we give up
  assign rq_on   = (state == request) || (state == wait_ack);

  always_comb begin
    state_d  = state;
    pend_d   = pend;
    rd_a_d   = rd_a;
    rd_b_d   = rd_b;
    dpar_d   = dpar;
    nxm_hit  = 1'b0;
    apar_hit = 1'b0;
    case (state)
      idle: begin
        if (req) begin
          dpar_d  = 1'b0;
          state_d = request;
        end
      end
      request: state_d = wait_ack;
      wait_ack: begin
        // Error wins, then acknowledge, then timeout
        if (mem.mem_error) begin
          apar_hit = mem.adr_par_err;
          state_d  = finish;
        end else if (ack) begin
          pend_d  = rq_mask;
          state_d = xfer;
        end else if (timeout) begin
          nxm_hit = 1'b1;
          state_d = finish;
        end
      end
      xfer: begin
        if (rq_wr) begin
          if (word_b || !rq_mask[1]) state_d = finish;
        end else begin
          // Collect read words as they show up
          if (mem.mem_data_valid_a) begin
            rd_a_d    = mem.mem_data_in;
            pend_d[0] = 1'b0;
          end
          if (mem.mem_data_valid_b) begin
            rd_b_d    = mem.mem_data_in;
            pend_d[1] = 1'b0;
          end
          dpar_d = dpar | mem.mem_data_par_err;
          if (pend_d == 2'b00) state_d = finish;
        end
      end
      finish: state_d = idle;
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge sbus_clk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= idle;
      rq_wr        <= 1'b0;
      rq_mask      <= '0;
      rq_diag_adr  <= 1'b0;
      rq_diag_data <= 1'b0;
      word_b       <= 1'b0;
      pend         <= '0;
      timer        <= '0;
      dpar         <= 1'b0;
      err_nxm      <= 1'b0;
      err_adr_par  <= 1'b0;
      err_data_par <= 1'b0;
    end else begin
      state <= state_d;
      pend  <= pend_d;
      dpar  <= dpar_d;
      timer <= (state == wait_ack) ? timer + 1'b1 : '0;
      if (state == idle && req) begin
        rq_wr        <= req_wr;
        rq_mask      <= req_mask;
        rq_diag_adr  <= diag_adr_par;
        rq_diag_data <= diag_data_par;
      end
      // Skip word A when only B is selected
      if (state == wait_ack) word_b <= ~rq_mask[0];
      else if (state == xfer) word_b <= 1'b1;
      // Results change only on the way into done
      if (state_d == finish) begin
        err_nxm      <= nxm_hit;
        err_adr_par  <= apar_hit;
        err_data_par <= dpar_d;
      end
    end
  end

  // Payload, no reset
  always_ff @(posedge sbus_clk) begin
    if (state == idle && req) begin
      rq_adr     <= req_adr;
      rq_wdata_a <= req_wdata_a;
      rq_wdata_b <= req_wdata_b;
    end
    rd_a <= rd_a_d;
    rd_b <= rd_b_d;
    if (state_d == finish) begin
      rdata_a <= rd_a_d;
      rdata_b <= rd_b_d;
    end
  end

  always_comb begin
    mem.mem_rq           = rq_on;
    mem.mem_rd_rq        = rq_on & ~rq_wr;
    mem.mem_wr_rq        = rq_on & rq_wr;
    mem.mem_start_a      = rq_on & rq_mask[0];
    mem.mem_start_b      = rq_on & rq_mask[1];
    mem.sbus_adr_hold    = busy & ~done;
    mem.pma              = rq_adr;
    mem.mem_data_to_mem  = (state == xfer) & rq_wr;
    // One word per cycle, A first
    mem.mb               = word_b ? rq_wdata_b : rq_wdata_a;
    mem.data_valid_a_out = mem.mem_data_to_mem & ~word_b & rq_mask[0];
    mem.data_valid_b_out = mem.mem_data_to_mem & word_b & rq_mask[1];
    mem.diag_adr_par     = rq_diag_adr;
    mem.diag_data_par    = rq_diag_data;
    // Power-fail crowbar resets the memory controller
    mem.diag_mem_reset   = crobar;
  end

endmodule

`default_nettype wire

//--- hdl/sbus_mem_ctl.sv
`timescale 1ns/10ps
`default_nettype none

module sbus_mem_ctl (
  input wire  sbus_clk,
  input wire  arst_n,
  sbus_if.mem sbus
);
  import kl_sbus_pkg::*;

  typedef enum logic [2:0] {
    m_idle,
    m_wait,
    m_write,
    m_read,
    m_drop
  } mem_state_e;

  mem_state_e state;
  dly_t       cnt;
  logic       wr;
  logic [1:0] sel;
  logic [1:0] pend;
  logic [1:0] pend_w;
  pair_idx_t  pair;
  // Storage array with one parity bit per word
  word_t      arr [MEM_WORDS];
  logic       par_arr [MEM_WORDS];

  // Words still expected after this cycle's write strobes
  assign pend_w = pend & ~{sbus.data_valid_b_out, sbus.data_valid_a_out};

  always_ff @(posedge sbus_clk or negedge arst_n) begin
    if (!arst_n) begin
      state             <= m_idle;
      cnt               <= '0;
      wr                <= 1'b0;
      sel               <= '0;
      pend              <= '0;
      pair              <= '0;
      sbus.ackn_a       <= 1'b0;
      sbus.ackn_b       <= 1'b0;
      sbus.error        <= 1'b0;
      sbus.adr_par_err  <= 1'b0;
      sbus.data_valid_a <= 1'b0;
      sbus.data_valid_b <= 1'b0;
    end else begin
      // Response strobes are single-cycle pulses
      sbus.ackn_a       <= 1'b0;
      sbus.ackn_b       <= 1'b0;
      sbus.error        <= 1'b0;
      sbus.adr_par_err  <= 1'b0;
      sbus.data_valid_a <= 1'b0;
      sbus.data_valid_b <= 1'b0;
      if (sbus.mem_reset) begin
        state <= m_idle;
      end else begin
        case (state)
          m_idle: begin
            if (sbus.rq && (sbus.rd_rq || sbus.wr_rq)) begin
              wr    <= sbus.wr_rq;
              sel   <= {sbus.start_b, sbus.start_a};
              cnt   <= dly_t'(ACK_DELAY - 1);
              state <= m_wait;
            end
          end
          m_wait: begin
            // Address is stable from the translator hold register here
            if (!sbus.rq) begin
              state <= m_idle;
            end else if (cnt != '0) begin
              cnt <= cnt - 1'b1;
            end else if (sbus.adr_par != ~^sbus.adr) begin
              sbus.error       <= 1'b1;
              sbus.adr_par_err <= 1'b1;
              state            <= m_drop;
            end else if (sbus.adr >= adr_t'(MEM_WORDS)) begin
              // Non-existent memory stays silent
              state <= m_drop;
            end else begin
              // Empty pair acknowledges on A
              sbus.ackn_a <= sel[0] | ~sel[1];
              sbus.ackn_b <= sel[1];
              pend        <= sel;
              pair        <= sbus.adr[MEM_AW-1:1];
              cnt         <= dly_t'(RD_DELAY - 1);
              state       <= wr ? m_write : m_read;
            end
          end
          m_write: begin
            pend <= pend_w;
            if (pend_w == 2'b00) state <= m_idle;
          end
          m_read: begin
            if (cnt != '0) begin
              cnt <= cnt - 1'b1;
            end else if (pend[0]) begin
              sbus.data_valid_a <= 1'b1;
              pend[0]           <= 1'b0;
            end else if (pend[1]) begin
              sbus.data_valid_b <= 1'b1;
              pend[1]           <= 1'b0;
            end else begin
              state <= m_idle;
            end
          end
          // Wait for the requester to drop rq
          m_drop: if (!sbus.rq) state <= m_idle;
          default: state <= m_idle;
        endcase
      end
    end
  end

  // Array write port and read data register
  always_ff @(posedge sbus_clk) begin
    if (state == m_write) begin
      if (sbus.data_valid_a_out && pend[0]) begin
        arr[{pair, 1'b0}]     <= sbus.d_out;
        par_arr[{pair, 1'b0}] <= sbus.data_par_out;
      end
      if (sbus.data_valid_b_out && pend[1]) begin
        arr[{pair, 1'b1}]     <= sbus.d_out;
        par_arr[{pair, 1'b1}] <= sbus.data_par_out;
      end
    end
    // Word goes out with the parity it was stored with
    if (state == m_read && cnt == '0 && pend != 2'b00) begin
      sbus.d_in        <= pend[0] ? arr[{pair, 1'b0}] : arr[{pair, 1'b1}];
      sbus.data_par_in <= pend[0] ? par_arr[{pair, 1'b0}] : par_arr[{pair, 1'b1}];
    end
  end

endmodule

`default_nettype wire

//--- hdl/kl_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module kl_mem_top (
  input  wire                     sbus_clk,
  input  wire                     arst_n,
  input  wire                     crobar,
  input  wire                     req,
  input  wire                     req_wr,
  input  wire kl_mbox_pkg::wmask_t req_mask,
  input  wire kl_sbus_pkg::adr_t  req_adr,
  input  wire kl_sbus_pkg::word_t req_wdata_a,
  input  wire kl_sbus_pkg::word_t req_wdata_b,
  input  wire                     diag_adr_par,
  input  wire                     diag_data_par,
  output logic                    busy,
  output logic                    done,
  output kl_sbus_pkg::word_t      rdata_a,
  output kl_sbus_pkg::word_t      rdata_b,
  output logic                    err_nxm,
  output logic                    err_adr_par,
  output logic                    err_data_par
);

  // Port to translator
  mbox_mem_if mem_if ();
  // Translator to memory
  sbus_if     sbus ();

  // Request sequencer on the MBOX side
  mbox_mem_port u_port (
    .sbus_clk      (sbus_clk),
    .arst_n        (arst_n),
    .crobar        (crobar),
    .req           (req),
    .req_wr        (req_wr),
    .req_mask      (req_mask),
    .req_adr       (req_adr),
    .req_wdata_a   (req_wdata_a),
    .req_wdata_b   (req_wdata_b),
    .diag_adr_par  (diag_adr_par),
    .diag_data_par (diag_data_par),
    .busy          (busy),
    .done          (done),
    .rdata_a       (rdata_a),
    .rdata_b       (rdata_b),
    .err_nxm       (err_nxm),
    .err_adr_par   (err_adr_par),
    .err_data_par  (err_data_par),
    .mem           (mem_if)
  );

  mt0 u_mt0 (
    .sbus_clk (sbus_clk),
    .arst_n   (arst_n),
    .mbox     (mem_if),
    .sbus     (sbus)
  );

  // Memory controller with the array
  sbus_mem_ctl u_mem (
    .sbus_clk (sbus_clk),
    .arst_n   (arst_n),
    .sbus     (sbus)
  );

endmodule

`default_nettype wire

//--- tb/kl_mem_checker.sv
`timescale 1ns/10ps
`default_nettype none

module kl_mem_checker (
  input  wire                      sbus_clk,
  input  wire                      arst_n,
  input  wire                      req,
  input  wire                      req_wr,
  input  wire kl_mbox_pkg::wmask_t req_mask,
  input  wire kl_sbus_pkg::adr_t   req_adr,
  input  wire kl_sbus_pkg::word_t  req_wdata_a,
  input  wire kl_sbus_pkg::word_t  req_wdata_b,
  input  wire                      diag_adr_par,
  input  wire                      diag_data_par,
  input  wire                      busy,
  input  wire                      done,
  input  wire kl_sbus_pkg::word_t  rdata_a,
  input  wire kl_sbus_pkg::word_t  rdata_b,
  input  wire                      err_nxm,
  input  wire                      err_adr_par,
  input  wire                      err_data_par,
  output int                       n_pass,
  output int                       n_fail
);
  import kl_sbus_pkg::*;
  import kl_mbox_pkg::*;

  // Reference memory with a bad-parity flag per word
  word_t  model [MEM_WORDS];
  bit     bad_par [MEM_WORDS];
  // Request in flight
  bit     active;
  int     wait_cnt;
  int     idx;
  string  name;
  string  kind;
  logic   c_wr;
  wmask_t c_mask;
  adr_t   c_adr;
  word_t  c_wa;
  word_t  c_wb;
  logic   c_bad_adr;
  logic   c_bad_data;
  // One report per stuck busy episode
  bit     proto_err;
  bit     rst_err;
  // Set once a reset edge has passed
  bit     rst_seen;

  initial begin
    n_pass    = 0;
    n_fail    = 0;
    active    = 1'b0;
    wait_cnt  = 0;
    idx       = 0;
    proto_err = 1'b0;
    rst_err   = 1'b0;
    rst_seen  = 1'b0;
  end

  // Keeps the first mismatch of a test
  task automatic compare(input string what, input word_t exp, input word_t act,
                         inout bit ok, inout string msg);
    if (ok && act !== exp) begin
      ok  = 1'b0;
      msg = $sformatf("Fail %s %s expected %0h actual %0h", name, what, exp, act);
    end
  endtask

  task automatic close_test();
    logic  exp_nxm;
    logic  exp_apar;
    logic  exp_dpar;
    int    base;
    bit    ok;
    string msg;
    ok       = 1'b1;
    msg      = "";
    // Parity check comes before the range check in memory
    exp_apar = c_bad_adr;
    exp_nxm  = !c_bad_adr && (c_adr >= MEM_WORDS);
    exp_dpar = 1'b0;
    base     = int'(c_adr[MEM_AW-1:0]) & ~1;
    if (!exp_apar && !exp_nxm && !c_wr) begin
      if (c_mask[0]) exp_dpar = exp_dpar | bad_par[base];
      if (c_mask[1]) exp_dpar = exp_dpar | bad_par[base+1];
    end
    compare("err_nxm", word_t'(exp_nxm), word_t'(err_nxm), ok, msg);
    compare("err_adr_par", word_t'(exp_apar), word_t'(err_adr_par), ok, msg);
    compare("err_data_par", word_t'(exp_dpar), word_t'(err_data_par), ok, msg);
    // Only selected words of a clean read carry data
    if (!exp_apar && !exp_nxm && !c_wr) begin
      if (c_mask[0]) compare("rdata_a", model[base], rdata_a, ok, msg);
      if (c_mask[1]) compare("rdata_b", model[base+1], rdata_b, ok, msg);
    end
    if (ok) begin
      n_pass++;
      $display("Pass %s", name);
    end else begin
      n_fail++;
      $display("%s", msg);
    end
    // Write lands with the parity it was sent with
    if (c_wr && !exp_apar && !exp_nxm) begin
      if (c_mask[0]) begin
        model[base]   = c_wa;
        bad_par[base] = c_bad_data;
      end
      if (c_mask[1]) begin
        model[base+1]   = c_wb;
        bad_par[base+1] = c_bad_data;
      end
    end
  endtask

  always @(posedge sbus_clk) begin
    if (!arst_n) begin
      active = 1'b0;
      // Reset values are in place from the second reset edge on
      if (rst_seen && !rst_err &&
          (busy !== 1'b0 || done !== 1'b0 || err_nxm !== 1'b0 ||
           err_adr_par !== 1'b0 || err_data_par !== 1'b0)) begin
        $display("Outputs are not cleared during reset");
        rst_err = 1'b1;
        n_fail++;
      end
      rst_seen = 1'b1;
    end else begin
      if (active) begin
        wait_cnt++;
        if (done === 1'b1) begin
          close_test();
          active = 1'b0;
        end else if (wait_cnt > NXM_TIMEOUT + 10) begin
          $display("No done arrived for test %s", name);
          n_fail++;
          active = 1'b0;
        end else if (busy !== 1'b1 && !proto_err) begin
          $display("Busy dropped before done in test %s", name);
          proto_err = 1'b1;
          n_fail++;
        end
      end else if (done === 1'b1) begin
        $display("Done arrived with no request outstanding");
        n_fail++;
      end else if (busy !== 1'b0 && !proto_err) begin
        $display("Busy is high with no request outstanding");
        proto_err = 1'b1;
        n_fail++;
      end
      // Request is taken only while idle
      if (busy === 1'b0 && req === 1'b1) begin
        idx++;
        if (diag_adr_par) kind = "adr_par";
        else if (req_adr >= MEM_WORDS) kind = "nxm";
        else if (req_wr && diag_data_par) kind = "write_bad_par";
        else if (req_wr) kind = "write";
        else kind = "read";
        name       = $sformatf("%0d %s adr=%0h mask=%b", idx, kind, req_adr, req_mask);
        c_wr       = req_wr;
        c_mask     = req_mask;
        c_adr      = req_adr;
        c_wa       = req_wdata_a;
        c_wb       = req_wdata_b;
        c_bad_adr  = diag_adr_par;
        c_bad_data = diag_data_par;
        wait_cnt   = 0;
        proto_err  = 1'b0;
        active     = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/kl_mem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module kl_mem_tb;
  import kl_sbus_pkg::*;
  import kl_mbox_pkg::*;

  localparam int N_FILL     = MEM_WORDS / 2;
  localparam int N_RAND     = 160;
  localparam int N_DIRECTED = 12;
  localparam int N_TESTS    = N_FILL + N_RAND + N_DIRECTED;
  localparam int RST_CYCLES = 4;
  // Each test gets the NXM timeout plus margin for gaps and crobar
  localparam int WD_CYCLES  = N_TESTS * (NXM_TIMEOUT + 10) + RST_CYCLES + 20;

  logic   sbus_clk;
  logic   arst_n;
  logic   crobar;
  logic   req;
  logic   req_wr;
  wmask_t req_mask;
  adr_t   req_adr;
  word_t  req_wdata_a;
  word_t  req_wdata_b;
  logic   diag_adr_par;
  logic   diag_data_par;
  logic   busy;
  logic   done;
  word_t  rdata_a;
  word_t  rdata_b;
  logic   err_nxm;
  logic   err_adr_par;
  logic   err_data_par;
  int     n_pass;
  int     n_fail;
  int     issued;

  kl_mem_top dut (
    .sbus_clk (sbus_clk), .arst_n (arst_n), .crobar (crobar),
    .req (req), .req_wr (req_wr), .req_mask (req_mask), .req_adr (req_adr),
    .req_wdata_a (req_wdata_a), .req_wdata_b (req_wdata_b),
    .diag_adr_par (diag_adr_par), .diag_data_par (diag_data_par),
    .busy (busy), .done (done), .rdata_a (rdata_a), .rdata_b (rdata_b),
    .err_nxm (err_nxm), .err_adr_par (err_adr_par), .err_data_par (err_data_par)
  );

  kl_mem_checker u_checker (
    .sbus_clk (sbus_clk), .arst_n (arst_n), .req (req), .req_wr (req_wr),
    .req_mask (req_mask), .req_adr (req_adr),
    .req_wdata_a (req_wdata_a), .req_wdata_b (req_wdata_b),
    .diag_adr_par (diag_adr_par), .diag_data_par (diag_data_par),
    .busy (busy), .done (done), .rdata_a (rdata_a), .rdata_b (rdata_b),
    .err_nxm (err_nxm), .err_adr_par (err_adr_par), .err_data_par (err_data_par),
    .n_pass (n_pass), .n_fail (n_fail)
  );

  always #50 sbus_clk = ~sbus_clk;

  function automatic word_t rand_word();
    return word_t'({$urandom, $urandom});
  endfunction

  // One request after a random gap, then wait for done
  task automatic send_request(input logic wr, input wmask_t mask, input adr_t adr,
                              input logic bad_adr, input logic bad_data);
    int n;
    repeat ($urandom_range(3)) @(posedge sbus_clk);
    req           <= 1'b1;
    req_wr        <= wr;
    req_mask      <= mask;
    req_adr       <= adr;
    req_wdata_a   <= rand_word();
    req_wdata_b   <= rand_word();
    diag_adr_par  <= bad_adr;
    diag_data_par <= bad_data;
    @(posedge sbus_clk);
    req           <= 1'b0;
    diag_adr_par  <= 1'b0;
    diag_data_par <= 1'b0;
    issued++;
    // Stray request while busy must be dropped
    if ($urandom_range(3) == 0) begin
      @(posedge sbus_clk);
      req     <= 1'b1;
      req_wr  <= ~wr;
      req_adr <= adr_t'($urandom_range(MEM_WORDS - 1));
      @(posedge sbus_clk);
      req     <= 1'b0;
    end
    n = 0;
    while (done !== 1'b1 && n < NXM_TIMEOUT + 10) begin
      @(posedge sbus_clk);
      n++;
    end
  endtask

  // Power-fail crowbar between requests
  task automatic pulse_crobar();
    @(posedge sbus_clk);
    crobar <= 1'b1;
    repeat (2) @(posedge sbus_clk);
    crobar <= 1'b0;
  endtask

  initial begin
    int     sel;
    wmask_t mask;
    adr_t   adr;
    sbus_clk      = 1'b0;
    arst_n        = 1'b0;
    crobar        = 1'b0;
    req           = 1'b0;
    req_wr        = 1'b0;
    req_mask      = '0;
    req_adr       = '0;
    req_wdata_a   = '0;
    req_wdata_b   = '0;
    diag_adr_par  = 1'b0;
    diag_data_par = 1'b0;
    issued        = 0;
    void'($urandom(76));
    repeat (RST_CYCLES) @(posedge sbus_clk);
    arst_n <= 1'b1;

    // Array powers up unknown, so fill every pair first
    for (int i = 0; i < N_FILL; i++) begin
      send_request(1'b1, 2'b11, adr_t'(2 * i), 1'b0, 1'b0);
    end

    for (int i = 0; i < N_RAND; i++) begin
      sel  = $urandom_range(19);
      mask = wmask_t'($urandom_range(3));
      adr  = adr_t'($urandom_range(MEM_WORDS - 1));
      if (sel == 0) begin
        send_request(1'($urandom_range(1)), mask, adr, 1'b1, 1'b0);
      end else if (sel == 1) begin
        adr = adr_t'(MEM_WORDS + $urandom_range(1000));
        send_request(1'($urandom_range(1)), mask, adr, 1'b0, 1'b0);
      end else if (sel == 2) begin
        send_request(1'b1, mask, adr, 1'b0, 1'b1);
      end else if (sel == 3) begin
        pulse_crobar();
        send_request(1'b0, mask, adr, 1'b0, 1'b0);
      end else begin
        send_request(1'(sel % 2), mask, adr, 1'b0, 1'b0);
      end
    end

    // Address parity error drops the write
    adr = adr_t'($urandom_range(MEM_WORDS - 1));
    send_request(1'b1, 2'b11, adr, 1'b0, 1'b0);
    send_request(1'b1, 2'b11, adr, 1'b1, 1'b0);
    send_request(1'b0, 2'b11, adr, 1'b1, 1'b0);
    send_request(1'b0, 2'b11, adr, 1'b0, 1'b0);
    // Bad stored parity, then a clean rewrite
    adr = adr_t'($urandom_range(MEM_WORDS - 1));
    send_request(1'b1, 2'b11, adr, 1'b0, 1'b1);
    send_request(1'b0, 2'b01, adr, 1'b0, 1'b0);
    send_request(1'b1, 2'b11, adr, 1'b0, 1'b0);
    send_request(1'b0, 2'b11, adr, 1'b0, 1'b0);
    // Non-existent memory
    send_request(1'b0, 2'b11, adr_t'(MEM_WORDS + 4), 1'b0, 1'b0);
    send_request(1'b1, 2'b10, adr_t'(MEM_WORDS * 3), 1'b0, 1'b0);
    // Crobar keeps the array
    adr = adr_t'($urandom_range(MEM_WORDS - 1));
    send_request(1'b1, 2'b11, adr, 1'b0, 1'b0);
    pulse_crobar();
    send_request(1'b0, 2'b11, adr, 1'b0, 1'b0);

    repeat (4) @(posedge sbus_clk);
    $display("Requests %0d, passed %0d, failed %0d", issued, n_pass, n_fail);
    if (n_fail == 0 && n_pass == issued) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    repeat (WD_CYCLES) @(posedge sbus_clk);
    $display("Run did not finish within %0d cycles", WD_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- kl_mem.f
hdl/kl_sbus_pkg.sv
hdl/kl_mbox_pkg.sv
hdl/mbox_mem_if.sv
hdl/sbus_if.sv
hdl/mt0.sv
hdl/mbox_mem_port.sv
hdl/sbus_mem_ctl.sv
hdl/kl_mem_top.sv
tb/kl_mem_checker.sv
tb/kl_mem_tb.sv

//--- Bender.yml
package:
  name: kl_mem

sources:
  - hdl/kl_sbus_pkg.sv
  - hdl/kl_mbox_pkg.sv
  - hdl/mbox_mem_if.sv
  - hdl/sbus_if.sv
  - hdl/mt0.sv
  - hdl/mbox_mem_port.sv
  - hdl/sbus_mem_ctl.sv
  - hdl/kl_mem_top.sv
  - target: test
    files:
      - tb/kl_mem_checker.sv
      - tb/kl_mem_tb.sv
